// File: verilog.f
+incdir+include
hdl/rename_pkg.sv
hdl/rob_tag_alloc.sv
hdl/rat.sv
hdl/rename_stage.sv
hdl/rename_top.sv
dv/rename_tb.sv

// File: Bender.yml
package:
  name: rename

sources:
  - include_dirs:
      - include
    files:
      - hdl/rename_pkg.sv
      - hdl/rob_tag_alloc.sv
      - hdl/rat.sv
      - hdl/rename_stage.sv
      - hdl/rename_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/rename_tb.sv

// File: dv/rename_tb.sv
/*
 * Random self-checking testbench for the rename subsystem
 * Reference RAT and in-flight tag queue, per-cycle prediction,
 * watchdog and summary
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_tb import rename_pkg::*; ();

    localparam int W           = `PIPE_WIDTH;
    localparam int CLK_PERIOD  = 8;
    // Sum of all test lengths below
    localparam int TEST_CYCLES = 500;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    logic [W-1:0]            dec_valid;
    logic [`DATA_WIDTH-1:0]  dec_pc [W-1:0];
    op_class_e               dec_op [W-1:0];
    arch_reg_t               dec_rd [W-1:0];
    logic [W-1:0]            dec_has_rd;
    arch_reg_t               dec_rs1 [W-1:0];
    arch_reg_t               dec_rs2 [W-1:0];
    logic                    rename_rdy;
    logic                    dispatch_rdy;
    logic [W-1:0]            ren_valid;
    logic [`DATA_WIDTH-1:0]  ren_pc [W-1:0];
    op_class_e               ren_op [W-1:0];
    rob_tag_t                ren_dest_tag [W-1:0];
    rob_tag_t                ren_src1_tag [W-1:0];
    logic [W-1:0]            ren_src1_renamed;
    reg_data_t               ren_src1_data [W-1:0];
    rob_tag_t                ren_src2_tag [W-1:0];
    logic [W-1:0]            ren_src2_renamed;
    reg_data_t               ren_src2_data [W-1:0];
    logic                    commit_valid;
    arch_reg_t               commit_rd;
    reg_data_t               commit_data;

    // ------------------------------
    // Reference model state
    // ------------------------------
    reg_data_t               m_data [`NUM_ARCH_REGS];
    logic                    m_ren  [`NUM_ARCH_REGS];
    rob_tag_t                m_tag  [`NUM_ARCH_REGS];
    // In-flight tags, oldest first, with their destinations
    rob_tag_t                q_tag [$];
    arch_reg_t               q_rd  [$];
    rob_tag_t                m_tail;
    logic                    exp_rdy;
    logic                    accepted;
    logic [W-1:0]            exp_valid;
    logic [`DATA_WIDTH-1:0]  exp_pc [W];
    op_class_e               exp_op [W];
    rob_tag_t                exp_dest [W];
    rob_tag_t                exp_s1_tag [W];
    logic                    exp_s1_ren [W];
    reg_data_t               exp_s1_data [W];
    rob_tag_t                exp_s2_tag [W];
    logic                    exp_s2_ren [W];
    reg_data_t               exp_s2_data [W];

    integer                  seed = 35110;
    int                      n_checks = 0;
    int                      n_errors = 0;

    rename_top dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog sized from the test lengths
    initial begin
        #(TEST_CYCLES * 20 * CLK_PERIOD);
        $display("Timeout: run exceeded its cycle budget without finishing");
        $display("Checks failed");
        $finish;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    task automatic compare_field(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // RAT lookup on pre-write state with the retire bypass
    function automatic void model_read(input arch_reg_t r, input logic retire,
                                       input rob_tag_t rtag, output reg_data_t d,
                                       output logic rn, output rob_tag_t t);
        d  = m_data[r];
        rn = m_ren[r];
        t  = m_tag[r];
        if (r == '0) begin
            d  = '0;
            rn = 1'b0;
        end else if (retire && m_ren[r] && (m_tag[r] == rtag)) begin
            d  = commit_data;
            rn = 1'b0;
        end
    endfunction

    // ------------------------------
    // Stimulus, one cycle
    // ------------------------------
    task automatic drive_inputs(input int c, input int commit_pct, input int commit_start,
                                input int disp_pct, input int flush_pct,
                                input int valid_mode, input bit force_fwd);
        // Decode holds a group until it is taken
        if (accepted) begin
            case (valid_mode)
                1:       dec_valid = 2'b11;
                2:       dec_valid = 2'b10;
                default: dec_valid = W'(rand_below(4));
            endcase
            for (int l = 0; l < W; l++) begin
                dec_pc[l]     = $random(seed);
                dec_op[l]     = op_class_e'(rand_below(5));
                // Narrow register range for plenty of dependencies
                dec_rd[l]     = arch_reg_t'(rand_below(8));
                dec_has_rd[l] = rand_below(4) != 0;
                dec_rs1[l]    = arch_reg_t'(rand_below(8));
                dec_rs2[l]    = arch_reg_t'(rand_below(8));
            end
            if (force_fwd) begin
                dec_has_rd[0] = 1'b1;
                if (dec_rd[0] == '0)
                    dec_rd[0] = 5'd1;
                dec_rs1[1] = dec_rd[0];
                if (rand_below(2) != 0)
                    dec_rs2[1] = dec_rd[0];
            end
        end
        dispatch_rdy = rand_below(100) < disp_pct;
        commit_valid = (c >= commit_start) && (rand_below(100) < commit_pct);
        // Commit names the oldest instruction's destination
        commit_rd    = (q_rd.size() != 0) ? q_rd[0] : arch_reg_t'(rand_below(32));
        commit_data  = $random(seed);
        flush        = rand_below(100) < flush_pct;
    endtask

    // ------------------------------
    // Prediction and model update
    // ------------------------------
    task automatic model_step;
        int         free;
        int         n_need;
        int         slot;
        logic       fire;
        logic       retire;
        logic       lane0_wr;
        rob_tag_t   rtag;
        rob_tag_t   ltag [W];
        rob_tag_t   s1t [W];
        rob_tag_t   s2t [W];
        logic       s1r [W];
        logic       s2r [W];
        reg_data_t  s1d [W];
        reg_data_t  s2d [W];

        free   = `ROB_DEPTH - q_tag.size();
        // Valid lanes take consecutive tags from the tail
        n_need = 0;
        for (int l = 0; l < W; l++) begin
            ltag[l] = m_tail + rob_tag_t'(n_need);
            if (dec_valid[l])
                n_need++;
        end
        exp_rdy = dispatch_rdy && (n_need <= free);
        compare_field(rename_rdy, exp_rdy, "rename_rdy");
        fire    = exp_rdy && (n_need != 0);
        retire  = commit_valid && (q_tag.size() != 0);
        rtag    = retire ? q_tag[0] : '0;
        lane0_wr = dec_valid[0] && dec_has_rd[0] && (dec_rd[0] != '0);
        for (int l = 0; l < W; l++) begin
            model_read(dec_rs1[l], retire, rtag, s1d[l], s1r[l], s1t[l]);
            model_read(dec_rs2[l], retire, rtag, s2d[l], s2r[l], s2t[l]);
        end
        // Lane 1 depends on lane 0 inside the group
        if (lane0_wr && (dec_rs1[1] == dec_rd[0])) begin
            s1t[1] = ltag[0];
            s1r[1] = 1'b1;
        end
        if (lane0_wr && (dec_rs2[1] == dec_rd[0])) begin
            s2t[1] = ltag[0];
            s2r[1] = 1'b1;
        end
        accepted = exp_rdy || (dec_valid == '0) || flush;

        if (flush) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++)
                m_ren[r] = 1'b0;
            q_tag.delete();
            q_rd.delete();
            m_tail    = '0;
            exp_valid = '0;
        end else begin
            if (dispatch_rdy)
                exp_valid = '0;
            if (retire) begin
                if (commit_rd != '0) begin
                    m_data[commit_rd] = commit_data;
                    if (m_tag[commit_rd] == rtag)
                        m_ren[commit_rd] = 1'b0;
                end
                void'(q_tag.pop_front());
                void'(q_rd.pop_front());
            end
            if (fire) begin
                slot = 0;
                for (int l = 0; l < W; l++) begin
                    if (dec_valid[l]) begin
                        // Valid lanes packed from slot 0 upward
                        exp_valid[slot]   = 1'b1;
                        exp_pc[slot]      = dec_pc[l];
                        exp_op[slot]      = dec_op[l];
                        exp_dest[slot]    = ltag[l];
                        exp_s1_tag[slot]  = s1t[l];
                        exp_s1_ren[slot]  = s1r[l];
                        exp_s1_data[slot] = s1d[l];
                        exp_s2_tag[slot]  = s2t[l];
                        exp_s2_ren[slot]  = s2r[l];
                        exp_s2_data[slot] = s2d[l];
                        slot++;
                        q_tag.push_back(ltag[l]);
                        q_rd.push_back(dec_has_rd[l] ? dec_rd[l] : arch_reg_t'(0));
                        if (dec_has_rd[l] && (dec_rd[l] != '0)) begin
                            m_ren[dec_rd[l]] = 1'b1;
                            m_tag[dec_rd[l]] = ltag[l];
                        end
                    end
                end
                m_tail = m_tail + rob_tag_t'(slot);
            end
        end
    endtask

    task automatic compare_outputs;
        compare_field(ren_valid, exp_valid, "ren_valid");
        for (int s = 0; s < W; s++) begin
            if (exp_valid[s]) begin
                compare_field(ren_pc[s], exp_pc[s], $sformatf("slot %0d pc", s));
                compare_field(ren_op[s], exp_op[s], $sformatf("slot %0d op", s));
                compare_field(ren_dest_tag[s], exp_dest[s], $sformatf("slot %0d dest", s));
                compare_field(ren_src1_renamed[s], exp_s1_ren[s],
                              $sformatf("slot %0d s1 ren", s));
                compare_field(ren_src2_renamed[s], exp_s2_ren[s],
                              $sformatf("slot %0d s2 ren", s));
                // Tag while renamed and value when not
                if (exp_s1_ren[s])
                    compare_field(ren_src1_tag[s], exp_s1_tag[s],
                                  $sformatf("slot %0d s1 tag", s));
                else
                    compare_field(ren_src1_data[s], exp_s1_data[s],
                                  $sformatf("slot %0d s1 data", s));
                if (exp_s2_ren[s])
                    compare_field(ren_src2_tag[s], exp_s2_tag[s],
                                  $sformatf("slot %0d s2 tag", s));
                else
                    compare_field(ren_src2_data[s], exp_s2_data[s],
                                  $sformatf("slot %0d s2 data", s));
            end
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic run_test(input string name, input int cycles, input int commit_pct,
                            input int commit_start, input int disp_pct, input int flush_pct,
                            input int valid_mode, input bit force_fwd);
        int checks_at_start;
        int errors_at_start;

        checks_at_start = n_checks;
        errors_at_start = n_errors;
        for (int c = 0; c < cycles; c++) begin
            drive_inputs(c, commit_pct, commit_start, disp_pct, flush_pct,
                         valid_mode, force_fwd);
            #2;
            model_step();
            @(posedge clk);
            #1;
            compare_outputs();
        end
        $display("%-12s %0d checks, %0d errors", name,
                 n_checks - checks_at_start, n_errors - errors_at_start);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        dec_valid    = '0;
        dec_has_rd   = '0;
        dispatch_rdy = 1'b0;
        commit_valid = 1'b0;
        commit_rd    = '0;
        commit_data  = '0;
        for (int l = 0; l < W; l++) begin
            dec_pc[l]  = '0;
            dec_op[l]  = op_alu;
            dec_rd[l]  = '0;
            dec_rs1[l] = '0;
            dec_rs2[l] = '0;
        end
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            m_data[r] = '0;
            m_ren[r]  = 1'b0;
            m_tag[r]  = '0;
        end
        m_tail    = '0;
        exp_valid = '0;
        accepted  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_test("basic",     120, 50,  0, 100,  0, 0, 1'b0);
        run_test("forward",    60, 60,  0, 100,  0, 1, 1'b1);
        // No commits at first so the ROB fills and stalls
        run_test("rob_full",   60, 50, 30, 100,  0, 1, 1'b0);
        run_test("stall",      80, 40,  0,  50,  0, 0, 1'b0);
        run_test("compact",    80, 70,  0,  90,  0, 2, 1'b0);
        run_test("flush",     100, 40,  0,  85, 10, 0, 1'b0);

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/rename_top.sv
/*
 * Rename subsystem top
 * Stage, RAT and ROB tag allocator behind the decode,
 * dispatch and commit ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_top import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    // Decode
    input  logic [`PIPE_WIDTH-1:0]  dec_valid,
    input  logic [`DATA_WIDTH-1:0]  dec_pc           [`PIPE_WIDTH-1:0],
    input  op_class_e               dec_op           [`PIPE_WIDTH-1:0],
    input  arch_reg_t               dec_rd           [`PIPE_WIDTH-1:0],
    input  logic [`PIPE_WIDTH-1:0]  dec_has_rd,
    input  arch_reg_t               dec_rs1          [`PIPE_WIDTH-1:0],
    input  arch_reg_t               dec_rs2          [`PIPE_WIDTH-1:0],
    output logic                    rename_rdy,
    // Dispatch
    input  logic                    dispatch_rdy,
    output logic [`PIPE_WIDTH-1:0]  ren_valid,
    output logic [`DATA_WIDTH-1:0]  ren_pc           [`PIPE_WIDTH-1:0],
    output op_class_e               ren_op           [`PIPE_WIDTH-1:0],
    output rob_tag_t                ren_dest_tag     [`PIPE_WIDTH-1:0],
    output rob_tag_t                ren_src1_tag     [`PIPE_WIDTH-1:0],
    output logic [`PIPE_WIDTH-1:0]  ren_src1_renamed,
    output reg_data_t               ren_src1_data    [`PIPE_WIDTH-1:0],
    output rob_tag_t                ren_src2_tag     [`PIPE_WIDTH-1:0],
    output logic [`PIPE_WIDTH-1:0]  ren_src2_renamed,
    output reg_data_t               ren_src2_data    [`PIPE_WIDTH-1:0],
    // Commit
    input  logic                    commit_valid,
    input  arch_reg_t               commit_rd,
    input  reg_data_t               commit_data
);

    // ------------------------------
    // Stage to allocator
    // ------------------------------
    logic [`PIPE_WIDTH-1:0]  alloc_req;
    logic [`PIPE_WIDTH-1:0]  alloc_gnt;
    rob_tag_t                alloc_tag   [`PIPE_WIDTH-1:0];
    logic                    alloc_take;

    // ------------------------------
    // Stage to RAT
    // ------------------------------
    arch_reg_t               rd_rs1      [`PIPE_WIDTH-1:0];
    arch_reg_t               rd_rs2      [`PIPE_WIDTH-1:0];
    reg_data_t               rs1_data    [`PIPE_WIDTH-1:0];
    reg_data_t               rs2_data    [`PIPE_WIDTH-1:0];
    logic [`PIPE_WIDTH-1:0]  rs1_renamed;
    logic [`PIPE_WIDTH-1:0]  rs2_renamed;
    rob_tag_t                rs1_tag     [`PIPE_WIDTH-1:0];
    rob_tag_t                rs2_tag     [`PIPE_WIDTH-1:0];
    logic [`PIPE_WIDTH-1:0]  wr_en;
    arch_reg_t               wr_rd       [`PIPE_WIDTH-1:0];
    rob_tag_t                wr_tag      [`PIPE_WIDTH-1:0];

    // Allocator head into the RAT clear and bypass
    logic                    retire_valid;
    rob_tag_t                retire_tag;

    // Rename datapath and output register
    rename_stage u_stage (.*);

    rat u_rat (.*);

    rob_tag_alloc u_alloc (.*);

endmodule

`default_nettype wire

// File: hdl/rename_stage.sv
/*
 * Two-wide rename stage
 * Per-lane source rename and tag assignment, lane 0 to lane 1
 * forwarding, single-lane compaction, decode/dispatch handshake
 * and dispatch-side pipeline register
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_stage import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    // Decode group
    input  logic [`PIPE_WIDTH-1:0]  dec_valid,
    input  logic [`DATA_WIDTH-1:0]  dec_pc           [`PIPE_WIDTH-1:0],
    input  op_class_e               dec_op           [`PIPE_WIDTH-1:0],
    input  arch_reg_t               dec_rd           [`PIPE_WIDTH-1:0],
    input  logic [`PIPE_WIDTH-1:0]  dec_has_rd,
    input  arch_reg_t               dec_rs1          [`PIPE_WIDTH-1:0],
    input  arch_reg_t               dec_rs2          [`PIPE_WIDTH-1:0],
    output logic                    rename_rdy,
    // Dispatch group
    input  logic                    dispatch_rdy,
    output logic [`PIPE_WIDTH-1:0]  ren_valid,
    output logic [`DATA_WIDTH-1:0]  ren_pc           [`PIPE_WIDTH-1:0],
    output op_class_e               ren_op           [`PIPE_WIDTH-1:0],
    output rob_tag_t                ren_dest_tag     [`PIPE_WIDTH-1:0],
    output rob_tag_t                ren_src1_tag     [`PIPE_WIDTH-1:0],
    output logic [`PIPE_WIDTH-1:0]  ren_src1_renamed,
    output reg_data_t               ren_src1_data    [`PIPE_WIDTH-1:0],
    output rob_tag_t                ren_src2_tag     [`PIPE_WIDTH-1:0],
    output logic [`PIPE_WIDTH-1:0]  ren_src2_renamed,
    output reg_data_t               ren_src2_data    [`PIPE_WIDTH-1:0],
    // Tag allocator
    output logic [`PIPE_WIDTH-1:0]  alloc_req,
    input  logic [`PIPE_WIDTH-1:0]  alloc_gnt,
    input  rob_tag_t                alloc_tag        [`PIPE_WIDTH-1:0],
    output logic                    alloc_take,
    // RAT lookups
    output arch_reg_t               rd_rs1           [`PIPE_WIDTH-1:0],
    output arch_reg_t               rd_rs2           [`PIPE_WIDTH-1:0],
    input  reg_data_t               rs1_data         [`PIPE_WIDTH-1:0],
    input  reg_data_t               rs2_data         [`PIPE_WIDTH-1:0],
    input  logic [`PIPE_WIDTH-1:0]  rs1_renamed,
    input  logic [`PIPE_WIDTH-1:0]  rs2_renamed,
    input  rob_tag_t                rs1_tag          [`PIPE_WIDTH-1:0],
    input  rob_tag_t                rs2_tag          [`PIPE_WIDTH-1:0],
    // RAT writes
    output logic [`PIPE_WIDTH-1:0]  wr_en,
    output arch_reg_t               wr_rd            [`PIPE_WIDTH-1:0],
    output rob_tag_t                wr_tag           [`PIPE_WIDTH-1:0]
);

    logic                    all_gnt_ok;
    logic                    fire;
    logic                    lane0_wr;
    logic                    shift;
    logic [`PIPE_WIDTH-1:0]  nxt_valid;
    logic                    slot_lane    [`PIPE_WIDTH-1:0];
    rob_tag_t                lane_s1_tag  [`PIPE_WIDTH-1:0];
    rob_tag_t                lane_s2_tag  [`PIPE_WIDTH-1:0];
    logic [`PIPE_WIDTH-1:0]  lane_s1_ren;
    logic [`PIPE_WIDTH-1:0]  lane_s2_ren;

    // ------------------------------
    // Handshake
    // ------------------------------
    assign alloc_req  = dec_valid;
    // Every valid lane must hold a tag
    assign all_gnt_ok = &(~dec_valid | alloc_gnt);
    assign rename_rdy = dispatch_rdy && all_gnt_ok;
    assign fire       = rename_rdy && (|dec_valid);
    assign alloc_take = fire;

    // ------------------------------
    // RAT ports
    // ------------------------------
    always_comb begin
        for (int l = 0; l < `PIPE_WIDTH; l++) begin
            rd_rs1[l] = dec_rs1[l];
            rd_rs2[l] = dec_rs2[l];
            wr_rd[l]  = dec_rd[l];
            wr_tag[l] = alloc_tag[l];
            // No mapping for x0
            wr_en[l]  = dec_valid[l] && dec_has_rd[l] && (dec_rd[l] != '0) && fire;
        end
    end

    // ------------------------------
    // Source rename and forwarding
    // ------------------------------
    assign lane0_wr = dec_valid[0] && dec_has_rd[0] && (dec_rd[0] != '0);

    always_comb begin
        for (int l = 0; l < `PIPE_WIDTH; l++) begin
            lane_s1_tag[l] = rs1_tag[l];
            lane_s1_ren[l] = rs1_renamed[l];
            lane_s2_tag[l] = rs2_tag[l];
            lane_s2_ren[l] = rs2_renamed[l];
        end
        // RAT has not seen lane 0's write yet
        if (lane0_wr && (dec_rs1[1] == dec_rd[0])) begin
            lane_s1_tag[1] = alloc_tag[0];
            lane_s1_ren[1] = 1'b1;
        end
        if (lane0_wr && (dec_rs2[1] == dec_rd[0])) begin
            lane_s2_tag[1] = alloc_tag[0];
            lane_s2_ren[1] = 1'b1;
        end
    end

    // ------------------------------
    // Compaction
    // ------------------------------
    // Lone lane 1 moves to slot 0
    assign shift        = !dec_valid[0] && dec_valid[1];
    assign nxt_valid    = shift ? 2'b01 : dec_valid;
    assign slot_lane[0] = shift;
    assign slot_lane[1] = 1'b1;

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ren_valid <= '0;
        end else if (flush) begin
            ren_valid <= '0;
        end else if (dispatch_rdy) begin
            // Bubble when no group fired
            ren_valid <= fire ? nxt_valid : '0;
        end
    end

    // Payload follows the valid bits only on fire
    always_ff @(posedge clk) begin
        if (fire) begin
            for (int s = 0; s < `PIPE_WIDTH; s++) begin
                ren_pc[s]           <= dec_pc[slot_lane[s]];
                ren_op[s]           <= dec_op[slot_lane[s]];
                ren_dest_tag[s]     <= alloc_tag[slot_lane[s]];
                ren_src1_tag[s]     <= lane_s1_tag[slot_lane[s]];
                ren_src1_renamed[s] <= lane_s1_ren[slot_lane[s]];
                ren_src1_data[s]    <= rs1_data[slot_lane[s]];
                ren_src2_tag[s]     <= lane_s2_tag[slot_lane[s]];
                ren_src2_renamed[s] <= lane_s2_ren[slot_lane[s]];
                ren_src2_data[s]    <= rs2_data[slot_lane[s]];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rat.sv
/*
 * Register alias table
 * Per-register data, renamed bit and ROB tag
 * Two-lane reads with retire bypass, two-lane rename writes,
 * commit write and clear, flush of all mappings
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rat import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    // Source lookups
    input  arch_reg_t               rd_rs1      [`PIPE_WIDTH-1:0],
    input  arch_reg_t               rd_rs2      [`PIPE_WIDTH-1:0],
    output reg_data_t               rs1_data    [`PIPE_WIDTH-1:0],
    output reg_data_t               rs2_data    [`PIPE_WIDTH-1:0],
    output logic [`PIPE_WIDTH-1:0]  rs1_renamed,
    output logic [`PIPE_WIDTH-1:0]  rs2_renamed,
    output rob_tag_t                rs1_tag     [`PIPE_WIDTH-1:0],
    output rob_tag_t                rs2_tag     [`PIPE_WIDTH-1:0],
    // New mappings from rename
    input  logic [`PIPE_WIDTH-1:0]  wr_en,
    input  arch_reg_t               wr_rd       [`PIPE_WIDTH-1:0],
    input  rob_tag_t                wr_tag      [`PIPE_WIDTH-1:0],
    // Commit side
    input  logic                    retire_valid,
    input  rob_tag_t                retire_tag,
    input  arch_reg_t               commit_rd,
    input  reg_data_t               commit_data
);

    reg_data_t  data_q    [`NUM_ARCH_REGS];
    logic       renamed_q [`NUM_ARCH_REGS];
    rob_tag_t   tag_q     [`NUM_ARCH_REGS];

    // ------------------------------
    // Read with retire bypass
    // ------------------------------
    function automatic void lookup(
        input  arch_reg_t r,
        output reg_data_t d,
        output logic      rn,
        output rob_tag_t  t
    );
        if (r == '0) begin
            // Hardwired zero
            d  = '0;
            rn = 1'b0;
            t  = '0;
        end else if (retire_valid && renamed_q[r] && (tag_q[r] == retire_tag)) begin
            // Producer retiring right now
            d  = commit_data;
            rn = 1'b0;
            t  = tag_q[r];
        end else begin
            d  = data_q[r];
            rn = renamed_q[r];
            t  = tag_q[r];
        end
    endfunction

    // Pre-write state plus bypass
    always_comb begin
        for (int l = 0; l < `PIPE_WIDTH; l++) begin
            lookup(rd_rs1[l], rs1_data[l], rs1_renamed[l], rs1_tag[l]);
            lookup(rd_rs2[l], rs2_data[l], rs2_renamed[l], rs2_tag[l]);
        end
    end

    // ------------------------------
    // Table update
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                data_q[r]    <= '0;
                renamed_q[r] <= 1'b0;
                tag_q[r]     <= '0;
            end
        end else if (flush) begin
            // Drop speculative mappings and keep values
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                renamed_q[r] <= 1'b0;
            end
        end else begin
            if (retire_valid && (commit_rd != '0)) begin
                data_q[commit_rd] <= commit_data;
                // Younger rename of same rd keeps its mapping
                if (tag_q[commit_rd] == retire_tag) begin
                    renamed_q[commit_rd] <= 1'b0;
                end
            end
            // Ascending lanes so lane 1 lands last and wins
            for (int l = 0; l < `PIPE_WIDTH; l++) begin
                if (wr_en[l]) begin
                    renamed_q[wr_rd[l]] <= 1'b1;
                    tag_q[wr_rd[l]]     <= wr_tag[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_tag_alloc.sv
/*
 * Circular ROB tag allocator
 * In-order per-lane grants, tail advance on take,
 * oldest-tag retire on commit, flush to empty
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rob_tag_alloc import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [`PIPE_WIDTH-1:0]  alloc_req,
    input  logic                    alloc_take,
    output logic [`PIPE_WIDTH-1:0]  alloc_gnt,
    output rob_tag_t                alloc_tag [`PIPE_WIDTH-1:0],
    input  logic                    commit_valid,
    output logic                    retire_valid,
    output rob_tag_t                retire_tag
);

    // Oldest in-flight tag
    rob_tag_t             head;
    // Next tag to hand out
    rob_tag_t             tail;
    // Extra bit to tell full from empty
    logic [`TAG_WIDTH:0]  count;
    logic [`TAG_WIDTH:0]  free_cnt;
    logic [1:0]           n_alloc;

    // ------------------------------
    // Grants and tags
    // ------------------------------
    assign free_cnt = (`TAG_WIDTH+1)'(`ROB_DEPTH) - count;

    // Lane 1 needs a second slot only if lane 0 also asks
    assign alloc_gnt[0] = alloc_req[0] && (free_cnt != '0);
    assign alloc_gnt[1] = alloc_req[1] &&
                          (alloc_req[0] ? (free_cnt >= 2) : (free_cnt != '0));

    assign alloc_tag[0] = tail;
    assign alloc_tag[1] = tail + rob_tag_t'(alloc_req[0]);

    // Tags consumed this cycle
    assign n_alloc = alloc_take ? ({1'b0, alloc_req[0]} + {1'b0, alloc_req[1]}) : 2'd0;

    // Commit on an empty allocator is dropped
    assign retire_valid = commit_valid && (count != '0);
    assign retire_tag   = head;

    // ------------------------------
    // Pointer update
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Take and retire may overlap
            tail  <= tail + rob_tag_t'(n_alloc);
            head  <= head + rob_tag_t'(retire_valid);
            count <= count + (`TAG_WIDTH+1)'(n_alloc) - (`TAG_WIDTH+1)'(retire_valid);
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_pkg.sv
/*
 * Rename shared types
 * Operation-class enum, architectural index, ROB tag
 * and register value typedefs
 */

`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    // ------------------------------
    // Index and payload types
    // ------------------------------

    // x0..x31
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

    // One ROB slot
    typedef logic [`TAG_WIDTH-1:0] rob_tag_t;

    // Committed register value
    typedef logic [`DATA_WIDTH-1:0] reg_data_t;

    // ------------------------------
    // Operation class
    // ------------------------------

    // Carried untouched to dispatch
    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_mul
    } op_class_e;

endpackage

`default_nettype wire

// File: include/rename_macros.svh
/*
 * Rename subsystem sizing
 * Pipe width, architectural register count, ROB depth,
 * register data width and derived ROB tag width
 */

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ------------------------------
// Frontend geometry
// ------------------------------

// Lanes per decode group
`define PIPE_WIDTH 2

// Integer register file size, x0 included
`define NUM_ARCH_REGS 32

// ------------------------------
// ROB and datapath
// ------------------------------

// Power-of-two tag count so pointers wrap for free
`define ROB_DEPTH 8
`define DATA_WIDTH 32
`define TAG_WIDTH $clog2(`ROB_DEPTH)

`endif
